// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= tb_fetch_decode
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "test ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import fe_pkg::*;
#(
    parameter int MAX_INSTR = 64
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic       i_stall,
    input  wire fetch_rec_t i_fetch,
    output redirect_t       o_redirect,
    output decoded_t        o_rec,
    output logic            o_valid
);

    localparam int ADDR_W = $clog2(MAX_INSTR);

    logic [5:0] opcode;
    logic       is_jump;
    decoded_t   dec;
    decoded_t   rec_q;
    logic       valid_q;

    assign opcode  = i_fetch.instr[31:26];
    assign is_jump = (opcode == OP_JUMP);

    // field split, same layout for every format
    always_comb begin
        dec.pc      = i_fetch.pc;
        dec.instr   = i_fetch.instr;
        dec.opcode  = opcode;
        dec.rs      = i_fetch.instr[25:21];
        dec.rt      = i_fetch.instr[20:16];
        dec.rd      = i_fetch.instr[15:11];
        dec.imm     = i_fetch.instr[15:0];
        dec.is_jump = is_jump;
    end

    // jump feedback, combinational from the fetch record
    always_comb begin
        o_redirect.taken  = i_fetch.valid && is_jump;
        // keep only the index bits of the 26-bit target field
        o_redirect.target = word_t'(i_fetch.instr[ADDR_W-1:0]);
    end

    // output register, valid pulses once per accepted instruction
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (i_stall) begin
            valid_q <= 1'b0;             // record held, no new pulse
        end else begin
            valid_q <= i_fetch.valid;
            if (i_fetch.valid) begin
                rec_q <= dec;
            end
        end
    end

    assign o_rec   = rec_q;
    assign o_valid = valid_q;

endmodule : decode_stage

`default_nettype wire

// File: rtl/fe_pkg.sv
`default_nettype none

package fe_pkg;

    // instruction and pc width
    typedef logic [31:0] word_t;

    // j-type opcode, target in the low 26 bits
    localparam logic [5:0] OP_JUMP = 6'b000010;

    // fetch to decode, one word with the pc that addressed it
    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } fetch_rec_t;

    // decode back to fetch
    typedef struct packed {
        logic  taken;
        word_t target;                   // already a memory index
    } redirect_t;

    // registered decode output
    typedef struct packed {
        word_t       pc;
        word_t       instr;
        logic [5:0]  opcode;             // instr[31:26]
        logic [4:0]  rs;                 // instr[25:21]
        logic [4:0]  rt;                 // instr[20:16]
        logic [4:0]  rd;                 // instr[15:11]
        logic [15:0] imm;                // instr[15:0]
        logic        is_jump;
    } decoded_t;

endpackage : fe_pkg

`default_nettype wire

// File: rtl/fetch_decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_decode_top
    import fe_pkg::*;
#(
    parameter int MAX_INSTR = 64         // must be a power of two
) (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst,
    input  wire logic                         i_stall,
    input  wire logic                         i_load_en,
    input  wire logic [$clog2(MAX_INSTR)-1:0] i_load_addr,
    input  wire word_t                        i_load_data,
    output decoded_t                          o_rec,
    output logic                              o_valid
);

    fetch_rec_t fetch_rec;               // fetch -> decode
    redirect_t  redirect;                // decode -> fetch, jump target

    fetch_stage #(
        .MAX_INSTR (MAX_INSTR)
    ) u_fetch_stage (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_stall     (i_stall),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_redirect  (redirect),
        .o_fetch     (fetch_rec)
    );

    decode_stage #(
        .MAX_INSTR (MAX_INSTR)
    ) u_decode_stage (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_stall    (i_stall),
        .i_fetch    (fetch_rec),
        .o_redirect (redirect),
        .o_rec      (o_rec),
        .o_valid    (o_valid)
    );

endmodule : fetch_decode_top

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
    import fe_pkg::*;
#(
    parameter int MAX_INSTR = 64
) (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst,
    input  wire logic                         i_stall,
    input  wire logic                         i_load_en,
    input  wire logic [$clog2(MAX_INSTR)-1:0] i_load_addr,
    input  wire word_t                        i_load_data,
    input  wire redirect_t                    i_redirect,
    output fetch_rec_t                        o_fetch
);

    localparam int ADDR_W = $clog2(MAX_INSTR);

    word_t      pc;
    word_t      pc_next;
    word_t      pc_rd;                   // pc of the word in the read register
    logic       rd_valid;                // read register holds a live word
    logic       run;
    word_t      rdata;
    fetch_rec_t fetch_q;

    assign run = !i_stall && !i_load_en;

    // next pc: jump, increment, or wrap
    always_comb begin
        if (i_redirect.taken) begin
            pc_next = i_redirect.target;
        end else if (pc < word_t'(MAX_INSTR - 1)) begin
            pc_next = pc + word_t'(1);
        end else begin
            pc_next = '0;
        end
    end

    instr_mem #(
        .MAX_INSTR (MAX_INSTR)
    ) u_instr_mem (
        .i_clk   (i_clk),
        .i_we    (i_load_en),
        .i_waddr (i_load_addr),
        .i_wdata (i_load_data),
        .i_re    (run),
        .i_raddr (pc[ADDR_W-1:0]),
        .o_rdata (rdata)
    );

    // pipeline is pc -> read register -> fetch record.
    // when decode sees a jump, the read register holds the delay slot and the
    // word read at the same edge is the one after it, so that one is squashed
    always_ff @(posedge i_clk) begin
        if (i_rst || i_load_en) begin
            pc            <= '0;         // restart at word 0 after a load
            rd_valid      <= 1'b0;
            fetch_q.valid <= 1'b0;
        end else if (!i_stall) begin
            pc            <= pc_next;
            pc_rd         <= pc;
            rd_valid      <= !i_redirect.taken; // drop the word past the slot
            fetch_q.valid <= rd_valid;
            fetch_q.pc    <= pc_rd;
            fetch_q.instr <= rdata;
        end
    end

    assign o_fetch = fetch_q;

endmodule : fetch_stage

`default_nettype wire

// File: rtl/instr_mem.sv
`timescale 1ns/10ps
`default_nettype none

module instr_mem
    import fe_pkg::*;
#(
    parameter int MAX_INSTR = 64         // word count, power of two
) (
    input  wire logic                         i_clk,
    input  wire logic                         i_we,
    input  wire logic [$clog2(MAX_INSTR)-1:0] i_waddr,
    input  wire word_t                        i_wdata,
    input  wire logic                         i_re,
    input  wire logic [$clog2(MAX_INSTR)-1:0] i_raddr,
    output word_t                             o_rdata
);

    word_t mem [MAX_INSTR];              // no reset on contents
    word_t rdata_q;

    // write port, driven by the loader
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, held while i_re is low
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            rdata_q <= mem[i_raddr];
        end
    end

    // fetch drops i_re while loading, so a read never meets a write

    assign o_rdata = rdata_q;

endmodule : instr_mem

`default_nettype wire

// File: sim.f
rtl/fe_pkg.sv
rtl/instr_mem.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/fetch_decode_top.sv
testbench/tb_clock.sv
testbench/tb_fetch_decode.sv

// File: testbench/sim_input.txt
# L addr word loads one instruction word, both hex
# E pc instr is the next expected output record, both hex
# P stall starts a program and stall 1 adds random stalls
# program 1 jumps from 3 to 8 with 4 as delay slot and wraps after 15
P 0
L 0 20010001
L 1 20020002
L 2 00221820
L 3 08000008
L 4 8c640004
L 5 ac650008
L 6 10a0fffc
L 7 3c07dead
L 8 34e7beef
L 9 00e83022
L a 0109482a
L b 2129ffff
L c 012a5824
L d 016c6825
L e 01ae7026
L f 01cf7827
E 0 20010001
E 1 20020002
E 2 00221820
E 3 08000008
E 4 8c640004
E 8 34e7beef
E 9 00e83022
E a 0109482a
E b 2129ffff
E c 012a5824
E d 016c6825
E e 01ae7026
E f 01cf7827
E 0 20010001
E 1 20020002
# program 2 loads mid-run and jumps from 5 to 13 with 6 as delay slot
P 1
L 0 24420001
L 1 00431020
L 2 8c440010
L 3 ac450014
L 4 3c061234
L 5 0800000d
L 6 34c65678
L 7 00c73820
L 8 10e0ffff
L 9 28e80005
L a 00085080
L b 000a5842
L c 016b6021
L d 318cff00
L e 01806809
L f 0000000c
E 0 24420001
E 1 00431020
E 2 8c440010
E 3 ac450014
E 4 3c061234
E 5 0800000d
E 6 34c65678
E d 318cff00
E e 01806809
E f 0000000c
E 0 24420001
E 1 00431020
E 2 8c440010

// File: testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;                    // first rising edge half a period in
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule : tb_clock

`default_nettype wire

// File: testbench/tb_fetch_decode.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_decode
    import fe_pkg::*;
();

    localparam int MAX_INSTR    = 16;    // small memory, wrap comes early
    localparam int ADDR_W       = $clog2(MAX_INSTR);
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 4;

    logic              clk;
    logic              rst;
    logic              stall;
    logic              load_en;
    logic [ADDR_W-1:0] load_addr;
    word_t             load_data;
    decoded_t          rec;
    logic              valid;

    logic [ADDR_W-1:0] ld_addr_q[$];     // all programs back to back
    word_t             ld_data_q[$];
    word_t             exp_pc_q[$];
    word_t             exp_instr_q[$];
    int                prog_loads[$];    // per program counts
    int                prog_recs[$];
    bit                prog_stalls[$];

    logic [31:0] lfsr;
    int          rec_idx;                // next expected record
    int          load_run;               // consecutive load edges
    bit          outputs_expected;
    bit          inputs_ready;
    int          limit_cycles;
    int          mismatch_cnt;
    int          missing_cnt;
    int          extra_cnt;
    int          other_cnt;

    tb_clock #(
        .PERIOD_NS (CLK_PERIOD)
    ) u_clock (
        .o_clk (clk)
    );

    fetch_decode_top #(
        .MAX_INSTR (MAX_INSTR)
    ) i_fetch_decode_top (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_stall     (stall),
        .i_load_en   (load_en),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .o_rec       (rec),
        .o_valid     (valid)
    );

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // field layout of the instruction word
    function automatic decoded_t expected_record(input word_t pc, input word_t instr);
        decoded_t r;
        r.pc      = pc;
        r.instr   = instr;
        r.opcode  = instr[31:26];
        r.rs      = instr[25:21];
        r.rt      = instr[20:16];
        r.rd      = instr[15:11];
        r.imm     = instr[15:0];
        r.is_jump = (instr[31:26] == OP_JUMP);
        return r;
    endfunction

    task automatic read_input_file();
        int          fd;
        int          c;
        int          n;
        int          v;
        logic [7:0]  ch;
        logic [31:0] a;
        word_t       w;
        fd = $fopen("testbench/sim_input.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("cannot open testbench/sim_input.txt");
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            if (ch == "#") begin
                while (c != -1 && c[7:0] != 8'h0a) begin
                    c = $fgetc(fd);      // rest of a comment line
                end
            end else if (ch == "P") begin
                n = $fscanf(fd, "%d", v);
                prog_stalls.push_back(v != 0);
                prog_loads.push_back(0);
                prog_recs.push_back(0);
            end else if (ch == "L" || ch == "E") begin
                n = $fscanf(fd, "%h %h", a, w);
                if (n != 2 || prog_loads.size() == 0) begin
                    other_cnt++;
                    $display("malformed %c line in input file", ch);
                end else if (ch == "L") begin
                    ld_addr_q.push_back(a[ADDR_W-1:0]);
                    ld_data_q.push_back(w);
                    prog_loads[prog_loads.size() - 1] += 1;
                end else begin
                    exp_pc_q.push_back(a);
                    exp_instr_q.push_back(w);
                    prog_recs[prog_recs.size() - 1] += 1;
                end
            end else if (ch != " " && ch != 8'h09 && ch != 8'h0a && ch != 8'h0d) begin
                other_cnt++;
                $display("unexpected character %c in input file", ch);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // inputs still hold the values seen at the last rising edge
    task automatic check_outputs();
        decoded_t exp_rec;
        if (load_en) begin
            load_run++;
        end else begin
            load_run = 0;
        end
        assert (!(rst && valid)) else begin
            other_cnt++;
            $display("%t: output valid after a reset edge", $time);
        end
        assert (!(stall && valid)) else begin
            other_cnt++;
            $display("%t: output valid after a stalled edge", $time);
        end
        assert (!(load_run >= 2 && valid)) else begin
            other_cnt++;
            $display("%t: record came out while loading", $time);
        end
        if (valid) begin
            assert (outputs_expected && rec_idx < exp_pc_q.size()) else begin
                extra_cnt++;
                $display("%t: extra record with pc %h, none expected", $time, rec.pc);
            end
            if (rec_idx < exp_pc_q.size()) begin
                exp_rec = expected_record(exp_pc_q[rec_idx], exp_instr_q[rec_idx]);
                assert (rec == exp_rec) else begin
                    mismatch_cnt++;
                    $write("mismatch %t: rec %0d got pc %h instr %h, exp pc %h instr %h",
                           $time, rec_idx, rec.pc, rec.instr, exp_rec.pc, exp_rec.instr);
                    $write(", op rs rt rd imm j got %h %h %h %h %h %b",
                           rec.opcode, rec.rs, rec.rt, rec.rd, rec.imm, rec.is_jump);
                    $display(" expected %h %h %h %h %h %b",
                             exp_rec.opcode, exp_rec.rs, exp_rec.rt, exp_rec.rd, exp_rec.imm,
                             exp_rec.is_jump);
                end
                rec_idx++;
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic run_programs();
        int p;
        int li;
        int first_rec;
        int stop_at;
        li        = 0;
        first_rec = 0;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;
        for (p = 0; p < prog_loads.size(); p++) begin
            repeat (prog_loads[p]) begin
                load_en   = 1'b1;
                stall     = 1'b0;        // a stall here would drop the record in decode
                load_addr = ld_addr_q[li];
                load_data = ld_data_q[li];
                li++;
                next_cycle();
            end
            load_en          = 1'b0;
            outputs_expected = 1'b1;
            first_rec += prog_recs[p];
            // one record is still in flight when the next load starts
            stop_at = (p < prog_loads.size() - 1) ? first_rec - 1 : first_rec;
            while (rec_idx < stop_at) begin
                if (prog_stalls[p]) begin
                    lfsr  = lfsr_next(lfsr);
                    stall = lfsr[0];
                end else begin
                    stall = 1'b0;
                end
                next_cycle();
            end
        end
        stall = 1'b1;                    // frozen, nothing more may come out
        repeat (DRAIN_CYCLES) next_cycle();
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatch, %0d missing, %0d extra, %0d other",
                 mismatch_cnt, missing_cnt, extra_cnt, other_cnt);
        if (mismatch_cnt + missing_cnt + extra_cnt + other_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst              = 1'b1;
        stall            = 1'b0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        lfsr             = 32'hb3d9_99a3;
        rec_idx          = 0;
        load_run         = 0;
        outputs_expected = 1'b0;
        read_input_file();
        limit_cycles = ld_addr_q.size() + 4 * exp_pc_q.size() + 100;
        inputs_ready = 1'b1;
        if (other_cnt == 0) begin
            run_programs();
        end
        finish_run();
    end

    // watchdog
    initial begin
        wait (inputs_ready);
        #(limit_cycles * CLK_PERIOD);
        other_cnt++;
        missing_cnt += exp_pc_q.size() - rec_idx;
        $display("timeout after %0d clock periods, %0d of %0d records seen",
                 limit_cycles, rec_idx, exp_pc_q.size());
        finish_run();
    end

endmodule : tb_fetch_decode

`default_nettype wire
